//--- src/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Opcodes.
`define ALU     6'h00
`define BRANCH  6'h01
`define J       6'h02
`define JAL     6'h03
`define BEQ     6'h04
`define BNE     6'h05
`define BLEZ    6'h06
`define BGTZ    6'h07
`define ADDI    6'h08
`define ADDIU   6'h09
`define SLTI    6'h0A
`define SLTIU   6'h0B
`define ANDI    6'h0C
`define ORI     6'h0D
`define XORI    6'h0E
`define LUI     6'h0F
`define LB      6'h20
`define LH      6'h21
`define LW      6'h23
`define LBU     6'h24
`define LHU     6'h25
`define SB      6'h28
`define SH      6'h29
`define SW      6'h2B

// Function field of SPECIAL.
`define SLL     6'h00
`define SRL     6'h02
`define SRA     6'h03
`define SLLV    6'h04
`define SRLV    6'h06
`define SRAV    6'h07
`define JR      6'h08
`define JALR    6'h09
`define ADD     6'h20
`define ADDU    6'h21
`define SUB     6'h22
`define SUBU    6'h23
`define AND     6'h24
`define OR      6'h25
`define XOR     6'h26
`define NOR     6'h27
`define SLT     6'h2A
`define SLTU    6'h2B

// REGIMM codes in the rt field.
`define BLTZ    5'h00
`define BGEZ    5'h01
`define BLTZAL  5'h10
`define BGEZAL  5'h11

// Memory width, low opcode bits.
`define BYTE    3'd0
`define HALF    3'd1
`define WORD    3'd3
`define BYTEU   3'd4
`define HALFU   3'd5

`define RESET_PC 32'h0000_0000

`endif

//--- src/mipsPkg.sv
package mipsPkg;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } jFields;

    // One instruction word, three views.
    typedef union packed {
        rFields rType;
        iFields iType;
        jFields jType;
    } instrWord;

endpackage

//--- src/decoder.sv
`timescale 1ns/10ps

`include "mips_config.svh"

module decoder (
    input  logic [5:0] OpCode,
    input  logic [5:0] FuncCode,
    input  logic [4:0] BraCode,
    output logic [1:0] RegDst,
    output logic       Branch,
    output logic       Jump,
    output logic       MemRead,
    output logic       MemtoReg,
    output logic       MemWrite,
    output logic       ALUSrc,
    output logic       RegWrite,
    output logic       ShiftSel,
    output logic       Unsgnsel,
    output logic [5:0] Func,
    output logic [2:0] MemFunc
);

    // RegDst picks rt (00), rd (01), r31 with link (10) or rd with link (11).
    always_comb
    begin
        RegDst   = 2'b00;
        Branch   = 1'b0;
        Jump     = 1'b0;
        MemRead  = 1'b0;
        MemtoReg = 1'b0;
        MemWrite = 1'b0;
        ALUSrc   = 1'b0;
        RegWrite = 1'b0;
        ShiftSel = 1'b0;
        Unsgnsel = 1'b0;
        Func     = 6'd0;
        MemFunc  = 3'd0;

        case (OpCode)
            `ALU:
                case (FuncCode)
                    `ADD, `ADDU, `SUB, `SUBU,
                    `AND, `OR, `XOR, `NOR,
                    `SLT, `SLTU, `SLL, `SRL,
                    `SRA, `SLLV, `SRLV, `SRAV:
                    begin
                        RegDst   = 2'b01;
                        Func     = FuncCode;
                        RegWrite = 1'b1;
                    end
                    `JR:
                    begin
                        Func = `JR;
                        Jump = 1'b1;
                    end
                    `JALR:
                    begin
                        RegDst   = 2'b11; // Link into rd.
                        Func     = `JALR;
                        Jump     = 1'b1;
                        RegWrite = 1'b1;
                    end
                    default:;
                endcase

            `BRANCH:
                case (BraCode)
                    `BLTZ, `BGEZ:
                    begin
                        Func   = {1'b0, BraCode};
                        Branch = 1'b1;
                    end
                    `BLTZAL, `BGEZAL:
                    begin
                        RegDst   = 2'b10; // Links whether taken or not.
                        Func     = {1'b0, BraCode};
                        Branch   = 1'b1;
                        RegWrite = 1'b1;
                    end
                    default:;
                endcase

            `BEQ, `BNE, `BLEZ, `BGTZ:
            begin
                Func   = OpCode;
                Branch = 1'b1;
            end

            `J:
            begin
                Func = `J;
                Jump = 1'b1;
            end

            `JAL:
            begin
                RegDst   = 2'b10;
                Func     = `JAL;
                Jump     = 1'b1;
                RegWrite = 1'b1;
            end

            `ADDI, `ADDIU, `SLTI:
            begin
                Func     = (OpCode == `SLTI) ? `SLT : `ADD;
                ALUSrc   = 1'b1;
                RegWrite = 1'b1;
            end

            `SLTIU:
            begin
                Unsgnsel = 1'b1;
                Func     = `SLTU;
                ALUSrc   = 1'b1;
                RegWrite = 1'b1;
            end

            `ANDI, `ORI, `XORI:
            begin
                Unsgnsel = 1'b1;
                Func     = {4'b1001, OpCode[1:0]}; // AND, OR, XOR in order.
                ALUSrc   = 1'b1;
                RegWrite = 1'b1;
            end

            `LUI:
            begin
                Func     = `ADD; // rs is r0.
                ALUSrc   = 1'b1;
                ShiftSel = 1'b1;
                RegWrite = 1'b1;
            end

            `LB, `LBU, `LH, `LHU, `LW:
            begin
                Func     = `ADD;
                MemFunc  = OpCode[2:0];
                ALUSrc   = 1'b1;
                MemRead  = 1'b1;
                MemtoReg = 1'b1;
                RegWrite = 1'b1;
            end

            `SB, `SH, `SW:
            begin
                Func     = `ADD;
                MemFunc  = OpCode[2:0];
                ALUSrc   = 1'b1;
                MemWrite = 1'b1;
            end

            default:;
        endcase
    end

endmodule

//--- src/execAlu.sv
`timescale 1ns/10ps

`include "mips_config.svh"

module execAlu (
    input  mipsPkg::instrWord instr,
    input  logic [31:0]       rsData,
    input  logic [31:0]       rtData,
    input  logic              ALUSrc,
    input  logic              Unsgnsel,
    input  logic              ShiftSel,
    input  logic [5:0]        Func,
    output logic [31:0]       aluResult
);

    logic [31:0] immExt;
    logic [31:0] opB;

    always_comb
    begin
        if (Unsgnsel)
            immExt = {16'd0, instr.iType.imm};
        else
            immExt = {{16{instr.iType.imm[15]}}, instr.iType.imm};
        if (ShiftSel)
            immExt = immExt << 16; // LUI.
    end

    assign opB = ALUSrc ? immExt : rtData;

    always_comb
    begin
        case (Func)
            `ADD, `ADDU: aluResult = rsData + opB; // No overflow trap.
            `SUB, `SUBU: aluResult = rsData - opB;
            `AND:        aluResult = rsData & opB;
            `OR:         aluResult = rsData | opB;
            `XOR:        aluResult = rsData ^ opB;
            `NOR:        aluResult = ~(rsData | opB);
            `SLT:        aluResult = {31'd0, $signed(rsData) < $signed(opB)};
            `SLTU:       aluResult = {31'd0, rsData < opB};
            `SLL:        aluResult = rtData << instr.rType.shamt;
            `SRL:        aluResult = rtData >> instr.rType.shamt;
            `SRA:        aluResult = $signed(rtData) >>> instr.rType.shamt;
            `SLLV:       aluResult = rtData << rsData[4:0];
            `SRLV:       aluResult = rtData >> rsData[4:0];
            `SRAV:       aluResult = $signed(rtData) >>> rsData[4:0];
            default:     aluResult = 32'd0;
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        wbEn,
    input  logic [4:0]  wbAddr,
    input  logic [31:0] wbData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (wbEn)
            regs[wbAddr] <= wbData;
    end

    // r0 reads as zero whatever was written.
    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/10ps

`include "mips_config.svh"

module fetchUnit (
    input  logic              clk,
    input  logic              rstN,
    input  logic [31:0]       instrData,
    input  logic              Branch,
    input  logic              Jump,
    input  logic [5:0]        Func,
    input  logic [31:0]       rsData,
    input  logic [31:0]       rtData,
    input  logic              loadStall,
    output logic [31:0]       pcAddr,
    output mipsPkg::instrWord execInstr,
    output logic [31:0]       linkAddr
);

    logic [31:0] pcReg;
    logic [31:0] execPc;
    logic        valid;
    logic [31:0] slotPc;
    logic [31:0] target;
    logic        taken;

    // Port data already lags the address by one cycle.
    assign execInstr = valid ? instrData : 32'd0;

    assign slotPc   = execPc + 32'd4;
    assign linkAddr = execPc + 32'd8;
    assign pcAddr   = pcReg;

    always_comb
    begin
        taken  = 1'b0;
        target = slotPc + {{14{execInstr.iType.imm[15]}}, execInstr.iType.imm, 2'b00};
        if (Branch)
        begin
            case (Func)
                `BEQ:                      taken = (rsData == rtData);
                `BNE:                      taken = (rsData != rtData);
                `BLEZ:                     taken = rsData[31] || (rsData == 32'd0);
                `BGTZ:                     taken = !rsData[31] && (rsData != 32'd0);
                {1'b0, `BLTZ}, {1'b0, `BLTZAL}: taken = rsData[31];
                {1'b0, `BGEZ}, {1'b0, `BGEZAL}: taken = !rsData[31];
                default:                   taken = 1'b0;
            endcase
        end
        else if (Jump)
        begin
            taken = 1'b1;
            if (Func == `JR || Func == `JALR)
                target = rsData;
            else
                target = {slotPc[31:28], execInstr.jType.target, 2'b00};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pcReg <= `RESET_PC;
            valid <= 1'b0;
        end
        else
        begin
            if (!loadStall)
                pcReg <= taken ? target : pcReg + 32'd4;
            valid <= !loadStall; // Bubble after a load.
        end
    end

    always_ff @(posedge clk)
    begin
        execPc <= pcReg;
    end

endmodule

//--- src/memStage.sv
`timescale 1ns/10ps

`include "mips_config.svh"

module memStage (
    input  logic              clk,
    input  logic              rstN,
    input  mipsPkg::instrWord execInstr,
    input  logic [1:0]        RegDst,
    input  logic              MemRead,
    input  logic              MemtoReg,
    input  logic              MemWrite,
    input  logic              RegWrite,
    input  logic [2:0]        MemFunc,
    input  logic [31:0]       aluResult,
    input  logic [31:0]       rtData,
    input  logic [31:0]       linkAddr,
    input  logic [31:0]       dataRdData,
    output logic [31:0]       dataAddr,
    output logic              dataRead,
    output logic              dataWrite,
    output logic [3:0]        dataBe,
    output logic [31:0]       dataWrData,
    output logic              loadStall,
    output logic              wbEn,
    output logic [4:0]        wbAddr,
    output logic [31:0]       wbData
);

    logic [1:0]  byteOff;
    logic [3:0]  storeBe;
    logic [4:0]  dstReg;
    logic        ldPend;
    logic [4:0]  ldReg;
    logic [1:0]  ldOff;
    logic [2:0]  ldFunc;
    logic [7:0]  ldByte;
    logic [15:0] ldHalf;
    logic [31:0] ldValue;

    assign byteOff   = aluResult[1:0];
    assign dataAddr  = {aluResult[31:2], 2'b00};
    assign dataRead  = MemRead;
    assign dataWrite = MemWrite;
    assign loadStall = MemRead;
    assign dataBe    = MemWrite ? storeBe : 4'b0000;

    // Little-endian lanes with the data replicated across them.
    always_comb
    begin
        case (MemFunc)
            `BYTE:
            begin
                storeBe    = 4'b0001 << byteOff;
                dataWrData = {4{rtData[7:0]}};
            end
            `HALF:
            begin
                storeBe    = byteOff[1] ? 4'b1100 : 4'b0011;
                dataWrData = {2{rtData[15:0]}};
            end
            default:
            begin
                storeBe    = 4'b1111;
                dataWrData = rtData;
            end
        endcase
    end

    always_comb
    begin
        case (RegDst)
            2'b00:   dstReg = execInstr.iType.rt;
            2'b10:   dstReg = 5'd31;
            default: dstReg = execInstr.rType.rd;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            ldPend <= 1'b0;
        else
            ldPend <= MemRead;
    end

    always_ff @(posedge clk)
    begin
        if (MemRead)
        begin
            ldReg  <= dstReg;
            ldOff  <= byteOff;
            ldFunc <= MemFunc;
        end
    end

    assign ldByte = dataRdData[{ldOff, 3'b000} +: 8];
    assign ldHalf = ldOff[1] ? dataRdData[31:16] : dataRdData[15:0];

    always_comb
    begin
        case (ldFunc)
            `BYTE:   ldValue = {{24{ldByte[7]}}, ldByte};
            `BYTEU:  ldValue = {24'd0, ldByte};
            `HALF:   ldValue = {{16{ldHalf[15]}}, ldHalf};
            `HALFU:  ldValue = {16'd0, ldHalf};
            default: ldValue = dataRdData;
        endcase
    end

    // Load data wins the bubble cycle.
    assign wbEn   = ldPend || (RegWrite && !MemtoReg);
    assign wbAddr = ldPend ? ldReg : dstReg;
    assign wbData = ldPend ? ldValue : (RegDst[1] ? linkAddr : aluResult);

endmodule

//--- src/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] pcAddr,
    input  logic [31:0] instrData,
    output logic [31:0] dataAddr,
    output logic        dataRead,
    output logic        dataWrite,
    output logic [3:0]  dataBe,
    output logic [31:0] dataWrData,
    input  logic [31:0] dataRdData
);

    import mipsPkg::*;

    instrWord    execInstr;
    logic [31:0] linkAddr;
    logic [1:0]  RegDst;
    logic        Branch;
    logic        Jump;
    logic        MemRead;
    logic        MemtoReg;
    logic        MemWrite;
    logic        ALUSrc;
    logic        RegWrite;
    logic        ShiftSel;
    logic        Unsgnsel;
    logic [5:0]  Func;
    logic [2:0]  MemFunc;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic        loadStall;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    fetchUnit i_fetch (
        .clk       (clk),
        .rstN      (rstN),
        .instrData (instrData),
        .Branch    (Branch),
        .Jump      (Jump),
        .Func      (Func),
        .rsData    (rsData),
        .rtData    (rtData),
        .loadStall (loadStall),
        .pcAddr    (pcAddr),
        .execInstr (execInstr),
        .linkAddr  (linkAddr)
    );

    decoder i_decoder (
        .OpCode   (execInstr.rType.op),
        .FuncCode (execInstr.rType.funct),
        .BraCode  (execInstr.iType.rt),
        .RegDst   (RegDst),
        .Branch   (Branch),
        .Jump     (Jump),
        .MemRead  (MemRead),
        .MemtoReg (MemtoReg),
        .MemWrite (MemWrite),
        .ALUSrc   (ALUSrc),
        .RegWrite (RegWrite),
        .ShiftSel (ShiftSel),
        .Unsgnsel (Unsgnsel),
        .Func     (Func),
        .MemFunc  (MemFunc)
    );

    regFile i_regFile (
        .clk    (clk),
        .rsAddr (execInstr.rType.rs),
        .rtAddr (execInstr.rType.rt),
        .rsData (rsData),
        .rtData (rtData),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

    execAlu i_alu (
        .instr     (execInstr),
        .rsData    (rsData),
        .rtData    (rtData),
        .ALUSrc    (ALUSrc),
        .Unsgnsel  (Unsgnsel),
        .ShiftSel  (ShiftSel),
        .Func      (Func),
        .aluResult (aluResult)
    );

    memStage i_mem (
        .clk        (clk),
        .rstN       (rstN),
        .execInstr  (execInstr),
        .RegDst     (RegDst),
        .MemRead    (MemRead),
        .MemtoReg   (MemtoReg),
        .MemWrite   (MemWrite),
        .RegWrite   (RegWrite),
        .MemFunc    (MemFunc),
        .aluResult  (aluResult),
        .rtData     (rtData),
        .linkAddr   (linkAddr),
        .dataRdData (dataRdData),
        .dataAddr   (dataAddr),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .dataBe     (dataBe),
        .dataWrData (dataWrData),
        .loadStall  (loadStall),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

endmodule

//--- bench/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] rOp(input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] rd, input logic [4:0] sh,
                                    input logic [5:0] fn);
    return {`ALU, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] iOp(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jOp(input logic [5:0] op, input int idx);
    return {op, idx[25:0]}; // Word index of the target.
endfunction

task automatic emit(input logic [31:0] w);
    rom[pcIdx] = w;
    pcIdx++;
endtask

task automatic addStore(input string name, input logic [31:0] addr,
                        input logic [3:0] be, input logic [31:0] data);
    stName.push_back(name);
    stAddr.push_back(addr);
    stBe.push_back(be);
    stData.push_back(data);
endtask

// Stores rX at 0x80 and expects the given value.
task automatic storeReg(input string name, input logic [4:0] r, input logic [31:0] value);
    emit(iOp(`SW, 5'd0, r, 16'h0080));
    addStore(name, 32'h80, 4'hF, value);
endtask

// Must never execute.
task automatic skipStore();
    emit(iOp(`SW, 5'd0, 5'd26, 16'h008C));
endtask

task automatic buildProgram();
    int linkIdx;
    pcIdx = 0;
    emit(iOp(`ADDIU, 0, 1, 16'h1234));
    emit(iOp(`ADDI, 0, 2, 16'hFFFB));
    emit(rOp(1, 2, 3, 0, `ADD));
    storeReg("add", 3, 32'h0000_122F);
    emit(rOp(1, 2, 4, 0, `SUB));
    storeReg("sub", 4, 32'h0000_1239);
    emit(rOp(1, 2, 5, 0, `AND));
    storeReg("and", 5, 32'h0000_1230);
    emit(rOp(1, 2, 6, 0, `OR));
    storeReg("or", 6, 32'hFFFF_FFFF);
    emit(rOp(1, 2, 7, 0, `XOR));
    storeReg("xor", 7, 32'hFFFF_EDCF);
    emit(rOp(1, 0, 8, 0, `NOR));
    storeReg("nor", 8, 32'hFFFF_EDCB);
    emit(rOp(2, 1, 9, 0, `SLT));
    storeReg("slt", 9, 32'd1);
    emit(rOp(2, 1, 10, 0, `SLTU));
    storeReg("sltu", 10, 32'd0);
    emit(rOp(0, 1, 11, 4, `SLL));
    storeReg("sll", 11, 32'h0001_2340);
    emit(rOp(0, 2, 12, 1, `SRA));
    storeReg("sra", 12, 32'hFFFF_FFFD);
    emit(rOp(0, 2, 13, 28, `SRL));
    storeReg("srl", 13, 32'h0000_000F);
    emit(rOp(13, 2, 14, 0, `SRLV));
    storeReg("srlv", 14, 32'h0001_FFFF);
    emit(rOp(13, 1, 27, 0, `SLLV));
    storeReg("sllv", 27, 32'h091A_0000);
    emit(rOp(13, 2, 27, 0, `SRAV));
    storeReg("srav", 27, 32'hFFFF_FFFF);

    emit(iOp(`ORI, 0, 15, 16'h9000));
    storeReg("ori", 15, 32'h0000_9000);
    emit(iOp(`SLTIU, 15, 16, 16'h8000)); // Zero-extended bound.
    storeReg("sltiu", 16, 32'd0);
    emit(iOp(`SLTI, 2, 17, 16'hFFFC));
    storeReg("slti", 17, 32'd1);
    emit(iOp(`ANDI, 2, 18, 16'hFF0F));
    storeReg("andi", 18, 32'h0000_FF0B);
    emit(iOp(`XORI, 2, 19, 16'h8001));
    storeReg("xori", 19, 32'hFFFF_7FFA);
    emit(iOp(`LUI, 0, 26, 16'hABCD));
    storeReg("lui", 26, 32'hABCD_0000);
    emit(iOp(`ADDI, 26, 28, 16'h8000));
    storeReg("addi", 28, 32'hABCC_8000);

    // RAM word 0x40 is E09C6F21, word 0x44 is E19D6E20.
    emit(iOp(`LB, 0, 20, 16'h0042));
    storeReg("lb neg", 20, 32'hFFFF_FF9C);
    emit(iOp(`LB, 0, 21, 16'h0041));
    storeReg("lb pos", 21, 32'h0000_006F);
    emit(iOp(`LBU, 0, 22, 16'h0043));
    storeReg("lbu", 22, 32'h0000_00E0);
    emit(iOp(`LH, 0, 23, 16'h0042));
    storeReg("lh", 23, 32'hFFFF_E09C);
    emit(iOp(`LHU, 0, 24, 16'h0042));
    storeReg("lhu", 24, 32'h0000_E09C);
    emit(iOp(`LW, 0, 25, 16'h0044));
    storeReg("lw", 25, 32'hE19D_6E20);

    emit(iOp(`BEQ, 1, 1, 16'd2));
    storeReg("beq taken slot", 3, 32'h0000_122F);
    skipStore();
    emit(iOp(`BEQ, 1, 2, 16'd2));
    storeReg("beq untaken slot", 4, 32'h0000_1239);
    storeReg("beq untaken fall", 5, 32'h0000_1230);
    emit(iOp(`BNE, 1, 2, 16'd2));
    storeReg("bne taken slot", 6, 32'hFFFF_FFFF);
    skipStore();
    emit(iOp(`BNE, 1, 1, 16'd2));
    storeReg("bne untaken slot", 7, 32'hFFFF_EDCF);
    storeReg("bne untaken fall", 8, 32'hFFFF_EDCB);
    emit(iOp(`BLEZ, 2, 0, 16'd2));
    storeReg("blez taken slot", 9, 32'd1);
    skipStore();
    emit(iOp(`BLEZ, 1, 0, 16'd2));
    storeReg("blez untaken slot", 11, 32'h0001_2340);
    storeReg("blez untaken fall", 12, 32'hFFFF_FFFD);
    emit(iOp(`BGTZ, 1, 0, 16'd2));
    storeReg("bgtz taken slot", 13, 32'h0000_000F);
    skipStore();
    emit(iOp(`BGTZ, 0, 0, 16'd2));
    storeReg("bgtz untaken slot", 14, 32'h0001_FFFF);
    storeReg("bgtz untaken fall", 15, 32'h0000_9000);
    emit(iOp(`BRANCH, 2, `BLTZ, 16'd2));
    storeReg("bltz taken slot", 17, 32'd1);
    skipStore();
    emit(iOp(`BRANCH, 1, `BLTZ, 16'd2));
    storeReg("bltz untaken slot", 18, 32'h0000_FF0B);
    storeReg("bltz untaken fall", 19, 32'hFFFF_7FFA);
    emit(iOp(`BRANCH, 0, `BGEZ, 16'd2));
    storeReg("bgez taken slot", 20, 32'hFFFF_FF9C);
    skipStore();
    emit(iOp(`BRANCH, 2, `BGEZ, 16'd2));
    storeReg("bgez untaken slot", 21, 32'h0000_006F);
    storeReg("bgez untaken fall", 22, 32'h0000_00E0);

    // Linking branches write r31 taken or not.
    linkIdx = pcIdx;
    emit(iOp(`BRANCH, 2, `BLTZAL, 16'd2));
    storeReg("bltzal taken slot", 3, 32'h0000_122F);
    skipStore();
    storeReg("bltzal taken link", 31, linkIdx * 4 + 8);
    linkIdx = pcIdx;
    emit(iOp(`BRANCH, 1, `BLTZAL, 16'd2));
    storeReg("bltzal untaken slot", 4, 32'h0000_1239);
    storeReg("bltzal untaken link", 31, linkIdx * 4 + 8);
    linkIdx = pcIdx;
    emit(iOp(`BRANCH, 2, `BGEZAL, 16'd2));
    storeReg("bgezal untaken slot", 5, 32'h0000_1230);
    storeReg("bgezal untaken link", 31, linkIdx * 4 + 8);

    emit(jOp(`J, pcIdx + 3));
    storeReg("j slot", 23, 32'hFFFF_E09C);
    skipStore();

    // Subroutines at words 200 and 204 store their link register at 0x84.
    rom[200] = rOp(31, 0, 0, 0, `JR);
    rom[201] = iOp(`SW, 0, 31, 16'h0084);
    rom[204] = rOp(28, 0, 0, 0, `JR);
    rom[205] = iOp(`SW, 0, 28, 16'h0084);

    linkIdx = pcIdx;
    emit(jOp(`JAL, 200));
    storeReg("jal slot", 1, 32'h0000_1234);
    addStore("jal link", 32'h84, 4'hF, linkIdx * 4 + 8);
    linkIdx = pcIdx;
    emit(iOp(`BRANCH, 1, `BGEZAL, 16'(199 - pcIdx)));
    storeReg("bgezal slot", 24, 32'h0000_E09C);
    addStore("bgezal link", 32'h84, 4'hF, linkIdx * 4 + 8);
    emit(iOp(`ADDIU, 0, 27, 16'd816));
    linkIdx = pcIdx;
    emit(rOp(27, 0, 28, 0, `JALR));
    storeReg("jalr slot", 25, 32'hE19D_6E20);
    addStore("jalr link", 32'h84, 4'hF, linkIdx * 4 + 8);

    emit(iOp(`SB, 0, 1, 16'h0081));
    addStore("sb lane 1", 32'h80, 4'b0010, 32'h3434_3434);
    emit(iOp(`SH, 0, 7, 16'h0082));
    addStore("sh upper", 32'h80, 4'b1100, 32'hEDCF_EDCF);
    emit(iOp(`SB, 0, 2, 16'h0083));
    addStore("sb lane 3", 32'h80, 4'b1000, 32'hFBFB_FBFB);
    emit(iOp(`LW, 0, 29, 16'h0080));
    storeReg("merged word", 29, 32'hFBCF_3420);

    emit(jOp(`J, pcIdx)); // Halt loop.
    emit(32'd0);
endtask

`endif

//--- bench/tbMipsCore.sv
`timescale 1ns/10ps

`include "mips_config.svh"

module tbMipsCore;

    logic        clk;
    logic        rstN;
    logic [31:0] pcAddr;
    logic [31:0] instrData;
    logic [31:0] dataAddr;
    logic        dataRead;
    logic        dataWrite;
    logic [3:0]  dataBe;
    logic [31:0] dataWrData;
    logic [31:0] dataRdData;

    logic [31:0] rom [256];
    logic [31:0] ram [64];
    int          pcIdx;
    string       stName [$];
    logic [31:0] stAddr [$];
    logic [3:0]  stBe [$];
    logic [31:0] stData [$];

    `include "tbProgram.svh"

    mipsCore i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .pcAddr     (pcAddr),
        .instrData  (instrData),
        .dataAddr   (dataAddr),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .dataBe     (dataBe),
        .dataWrData (dataWrData),
        .dataRdData (dataRdData)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    always @(posedge clk)
    begin
        instrData <= rom[pcAddr[9:2]]; // One cycle late.
    end

    always @(posedge clk)
    begin
        if (dataRead)
            dataRdData <= ram[dataAddr[7:2]];
        if (dataWrite)
            ram[dataAddr[7:2]] <= mergeBytes(ram[dataAddr[7:2]], dataWrData, dataBe);
    end

    task automatic checkValue(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Checks failed");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic checkReset(input string name);
        checkValue({name, " pcAddr"}, `RESET_PC, pcAddr);
        checkValue({name, " dataRead"}, 32'd0, {31'd0, dataRead});
        checkValue({name, " dataWrite"}, 32'd0, {31'd0, dataWrite});
    endtask

    task automatic waitStore(input int k);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!dataWrite && n < 200);
        if (!dataWrite)
        begin
            $display("Store %0d (%s) never came within 200 cycles", k, stName[k]);
            $display("Checks failed");
            $fatal(1, "Timeout");
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrData  = 32'd0;
        dataRdData = 32'd0;
        for (int i = 0; i < 256; i++)
            rom[i] = 32'd0;
        for (int i = 0; i < 64; i++)
            ram[i] = 32'hF08C_7F31 ^ (i * 32'h0101_0101);
        buildProgram();

        @(posedge clk);
        @(negedge clk);
        checkReset("in reset");
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkReset("after reset");

        for (int k = 0; k < stName.size(); k++)
        begin
            waitStore(k);
            checkValue({stName[k], " addr"}, stAddr[k], dataAddr);
            checkValue({stName[k], " be"}, {28'd0, stBe[k]}, {28'd0, dataBe});
            checkValue({stName[k], " data"}, stData[k], dataWrData);
            @(posedge clk);
        end

        // The halt loop must stay quiet.
        for (int n = 0; n < 40; n++)
        begin
            @(negedge clk);
            if (dataWrite)
            begin
                $display("A store appeared after the last expected one");
                $display("Checks failed");
                $fatal(1, "Extra store");
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- files.f
+incdir+src
+incdir+bench
src/mipsPkg.sv
src/decoder.sv
src/execAlu.sv
src/regFile.sv
src/fetchUnit.sv
src/memStage.sv
src/mipsCore.sv
bench/tbMipsCore.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - src
    files:
      - src/mipsPkg.sv
      - src/decoder.sv
      - src/execAlu.sv
      - src/regFile.sv
      - src/fetchUnit.sv
      - src/memStage.sv
      - src/mipsCore.sv
  - target: test
    include_dirs:
      - src
      - bench
    files:
      - bench/tbMipsCore.sv
